// ==== logic/sys_pkg.sv ====
`default_nettype none

package sys_pkg;

   // serial line timing
   localparam int CLKS_PER_BIT = 8;

   // memory geometry
   localparam int ADDR_W    = 4;
   localparam int DATA_W    = 8;
   localparam int MEM_DEPTH = 16;

   // internal reset pulse, counted from board reset release
   localparam int RST_START    = 5;
   localparam int RST_DURATION = 10;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // ASCII command and reply codes
   localparam data_t CMD_WRITE = 8'h57;
   localparam data_t CMD_READ  = 8'h52;
   localparam data_t REPLY_ACK = 8'h4B;

   // one request per command, valid for a single cycle
   typedef struct packed {
      logic  valid;
      logic  we;
      addr_t addr;
      data_t wdata;
   } mem_req_t;

endpackage

`default_nettype wire

// ==== logic/reset_pulse_gen.sv ====
`default_nettype none

module reset_pulse_gen (
   input  logic clk,
   input  logic rst_n,
   output logic sys_rst_n
);
   import sys_pkg::*;

   logic [$clog2(RST_START + RST_DURATION + 1)-1:0] cnt;
   logic                                            saturated;
   logic                                            in_window;

   assign saturated = (cnt == RST_START + RST_DURATION);
   assign in_window = (cnt >= RST_START) && !saturated;

   // free running until the end of the pulse, then held
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (!saturated) begin
         cnt <= cnt + 1'b1;
      end
   end

   // board reset keeps the system in reset as well
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sys_rst_n <= 1'b0;
      end else begin
         sys_rst_n <= !in_window;
      end
   end

   // once the pulse is over the system reset stays released
   a_no_second_pulse : assert property (
      @(posedge clk) disable iff (!rst_n)
      saturated |=> sys_rst_n
   );

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`default_nettype none

module uart_rx (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           rxd,
   output logic           rx_valid,
   output sys_pkg::data_t rx_data,
   output logic           rx_frame_err
);
   import sys_pkg::*;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t                       state;
   logic                            rx_meta;
   logic                            rx_sync;
   logic                            rx_prev;
   logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
   logic [$clog2(DATA_W)-1:0]       bit_idx;
   logic                            start_edge;
   logic                            bit_tick;

   assign start_edge = rx_prev && !rx_sync;
   assign bit_tick   = (clk_cnt == CLKS_PER_BIT - 1);

   // two flop synchroniser plus edge history, line idles high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rxd;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= RX_IDLE;
         clk_cnt      <= '0;
         bit_idx      <= '0;
         rx_valid     <= 1'b0;
         rx_frame_err <= 1'b0;
      end else begin
         rx_valid     <= 1'b0;
         rx_frame_err <= 1'b0;
         clk_cnt      <= clk_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (start_edge) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               // half a bit in, the start bit must still be low
               if (clk_cnt == CLKS_PER_BIT / 2 - 1) begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (bit_tick) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == DATA_W - 1) begin
                     state <= RX_STOP;
                  end
               end
            end
            default: begin
               if (bit_tick) begin
                  clk_cnt      <= '0;
                  rx_valid     <= 1'b1;
                  rx_frame_err <= !rx_sync;
                  state        <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // lsb arrives first, so shift in from the top
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_tick) begin
         rx_data <= {rx_sync, rx_data[DATA_W-1:1]};
      end
   end

   a_err_with_valid : assert property (
      @(posedge clk) disable iff (!rst_n)
      rx_frame_err |-> rx_valid
   );

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`default_nettype none

module uart_tx (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           tx_start,
   input  sys_pkg::data_t tx_data,
   output logic           txd,
   output logic           tx_busy
);
   import sys_pkg::*;

   logic [DATA_W:0]                 shift;
   logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
   logic [$clog2(DATA_W + 2)-1:0]   bit_idx;
   logic                            bit_end;

   assign bit_end = (clk_cnt == CLKS_PER_BIT - 1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         txd     <= 1'b1;
         tx_busy <= 1'b0;
         clk_cnt <= '0;
         bit_idx <= '0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            // start bit goes out right away
            txd     <= 1'b0;
            tx_busy <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
         end
      end else if (bit_end) begin
         clk_cnt <= '0;
         if (bit_idx == DATA_W + 1) begin
            // stop bit done
            tx_busy <= 1'b0;
            txd     <= 1'b1;
         end else begin
            txd     <= shift[0];
            bit_idx <= bit_idx + 1'b1;
         end
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   // data bits then stop bit, lsb first
   always_ff @(posedge clk) begin
      if (!tx_busy && tx_start) begin
         shift <= {1'b1, tx_data};
      end else if (tx_busy && bit_end) begin
         shift <= {1'b1, shift[DATA_W:1]};
      end
   end

   // the engine holds replies back while a frame is on the line
   a_no_start_when_busy : assert property (
      @(posedge clk) disable iff (!rst_n)
      tx_start |-> !tx_busy
   );

endmodule

`default_nettype wire

// ==== logic/word_mem.sv ====
`default_nettype none

module word_mem (
   input  logic             clk,
   input  logic             rst_n,
   input  sys_pkg::mem_req_t mem_req,
   output sys_pkg::data_t   rd_data
);
   import sys_pkg::*;

   data_t mem [MEM_DEPTH];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
         rd_data <= '0;
      end else if (mem_req.valid) begin
         if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
         end else begin
            // read data held until the next read
            rd_data <= mem[mem_req.addr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/monitor_engine.sv ====
`default_nettype none

module monitor_engine (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rx_valid,
   input  sys_pkg::data_t    rx_data,
   input  logic              rx_frame_err,
   output sys_pkg::mem_req_t mem_req,
   input  sys_pkg::data_t    rd_data,
   output logic              tx_start,
   output sys_pkg::data_t    tx_data,
   input  logic              tx_busy,
   output logic              trap
);
   import sys_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_WAIT_ADDR,
      S_WAIT_DATA,
      S_READ_WAIT,
      S_REPLY_PEND,
      S_TRAPPED
   } mon_state_t;

   mon_state_t state;
   logic       cmd_write;
   addr_t      addr;
   logic       reply_mem;
   logic       bad_frame;

   assign bad_frame = rx_valid && rx_frame_err;

   // reply byte is either the ack code or the word just read
   assign tx_data = reply_mem ? rd_data : REPLY_ACK;

   // sticky until reset
   assign trap = (state == S_TRAPPED);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= S_IDLE;
         cmd_write <= 1'b0;
         addr      <= '0;
         reply_mem <= 1'b0;
         mem_req   <= '0;
         tx_start  <= 1'b0;
      end else begin
         mem_req.valid <= 1'b0;
         tx_start      <= 1'b0;
         if (bad_frame && state != S_TRAPPED) begin
            state <= S_TRAPPED;
         end else begin
            case (state)
               S_IDLE: begin
                  if (rx_valid) begin
                     cmd_write <= (rx_data == CMD_WRITE);
                     if (rx_data == CMD_WRITE || rx_data == CMD_READ) begin
                        state <= S_WAIT_ADDR;
                     end else begin
                        state <= S_TRAPPED;
                     end
                  end
               end
               S_WAIT_ADDR: begin
                  if (rx_valid) begin
                     // high address bits are ignored
                     addr <= rx_data[ADDR_W-1:0];
                     if (cmd_write) begin
                        state <= S_WAIT_DATA;
                     end else begin
                        mem_req.valid <= 1'b1;
                        mem_req.we    <= 1'b0;
                        mem_req.addr  <= rx_data[ADDR_W-1:0];
                        state         <= S_READ_WAIT;
                     end
                  end
               end
               S_WAIT_DATA: begin
                  if (rx_valid) begin
                     mem_req.valid <= 1'b1;
                     mem_req.we    <= 1'b1;
                     mem_req.addr  <= addr;
                     mem_req.wdata <= rx_data;
                     reply_mem     <= 1'b0;
                     tx_start      <= !tx_busy;
                     state         <= tx_busy ? S_REPLY_PEND : S_IDLE;
                  end
               end
               S_READ_WAIT: begin
                  // rd_data lands in the same cycle tx_start goes high
                  reply_mem <= 1'b1;
                  tx_start  <= !tx_busy;
                  state     <= tx_busy ? S_REPLY_PEND : S_IDLE;
               end
               S_REPLY_PEND: begin
                  if (!tx_busy) begin
                     tx_start <= 1'b1;
                     state    <= S_IDLE;
                  end
               end
               default: begin
                  state <= S_TRAPPED;
               end
            endcase
         end
      end
   end

   // a new request needs a new command byte accepted in idle first
   a_one_req_per_cmd : assert property (
      @(posedge clk) disable iff (!rst_n)
      mem_req.valid |=> (!mem_req.valid until (rx_valid && state == S_IDLE))
   );

endmodule

`default_nettype wire

// ==== logic/top_system.sv ====
`default_nettype none

module top_system (
   input  logic clk,
   input  logic rst_n,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic trap
);
   import sys_pkg::*;

   logic     sys_rst_n;
   logic     rx_valid;
   data_t    rx_data;
   logic     rx_frame_err;
   mem_req_t mem_req;
   data_t    rd_data;
   logic     tx_start;
   data_t    tx_data;
   logic     tx_busy;

   // board reset pin is never pressed, so make our own pulse
   reset_pulse_gen reset_pulse (
      .clk       (clk),
      .rst_n     (rst_n),
      .sys_rst_n (sys_rst_n)
   );

   uart_rx rx (
      .clk          (clk),
      .rst_n        (sys_rst_n),
      .rxd          (uart_rxd),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .rx_frame_err (rx_frame_err)
   );

   word_mem mem (
      .clk     (clk),
      .rst_n   (sys_rst_n),
      .mem_req (mem_req),
      .rd_data (rd_data)
   );

   monitor_engine engine (
      .clk          (clk),
      .rst_n        (sys_rst_n),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .rx_frame_err (rx_frame_err),
      .mem_req      (mem_req),
      .rd_data      (rd_data),
      .tx_start     (tx_start),
      .tx_data      (tx_data),
      .tx_busy      (tx_busy),
      .trap         (trap)
   );

   uart_tx tx (
      .clk      (clk),
      .rst_n    (sys_rst_n),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .txd      (uart_txd),
      .tx_busy  (tx_busy)
   );

endmodule

`default_nettype wire

// ==== include/tb_uart_tasks.svh ====
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// start bit, 8 data bits lsb first, then the stop bit
// a low stop_bit gives a framing error on purpose
task automatic send_byte(input data_t value, input logic stop_bit);
   logic [9:0] frame;
   frame = {stop_bit, value, 1'b0};
   for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      uart_rxd = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk);
   end
   // back to idle, also after a bad stop bit
   @(negedge clk);
   uart_rxd = 1'b1;
endtask

// got stays low when no start bit shows up within max_cycles
task automatic recv_byte(output data_t value, output logic got, input int max_cycles);
   int waited;
   waited = 0;
   got    = 1'b0;
   value  = '0;
   while (!got && waited < max_cycles) begin
      @(negedge clk);
      waited++;
      got = (uart_txd === 1'b0);
   end
   if (got) begin
      // move to the middle of the start bit
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_txd !== 1'b0) begin
         $display("reply start bit did not last half a bit period");
         abort_run();
      end
      for (int i = 0; i < DATA_W; i++) begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         value[i] = uart_txd;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_txd !== 1'b1) begin
         $display("reply frame ended with a low stop bit");
         abort_run();
      end
   end
endtask

`endif

// ==== testbench/tb_top_system.sv ====
`default_nettype none

module tb_top_system;
   import sys_pkg::*;

   localparam int MAX_ENTRIES   = 16;
   localparam int REPLY_TIMEOUT = 42 * CLKS_PER_BIT;

   // one command of the stimulus table with what it should produce
   typedef struct packed {
      data_t      cmd;
      data_t      addr;
      data_t      data;
      logic [1:0] nbytes;
      logic       stop_ok;
      logic       reset_before;
      logic       group_end;
      logic       has_reply;
      data_t      exp_reply;
      logic       exp_trap;
   } cmd_entry_t;

   logic       clk;
   logic       rst_n;
   logic       uart_rxd;
   logic       uart_txd;
   logic       trap;
   cmd_entry_t cmd_table [MAX_ENTRIES];
   string      cmd_names [MAX_ENTRIES];
   int         num_entries;
   data_t      model [MEM_DEPTH];
   logic       model_trapped;

   top_system uut (
      .clk      (clk),
      .rst_n    (rst_n),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .trap     (trap)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

`include "tb_uart_tasks.svh"

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         $display("ERR %s expected 0x%02h actual 0x%02h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_trap(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s trap expected %b actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_line(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s uart_txd expected %b actual %b", name, exp, act);
         abort_run();
      end
   endtask

   // board reset, then wait until the internal pulse is over
   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      repeat (RST_START + RST_DURATION + 2) @(negedge clk);
   endtask

   // expected reply and trap follow the monitor rules on the model memory
   task automatic add_entry(input string name, input data_t cmd, input data_t addr,
                            input data_t data, input logic stop_ok,
                            input logic reset_before, input logic group_end);
      cmd_entry_t e;
      addr_t      a;
      logic       known;
      a     = addr[ADDR_W-1:0];
      known = (cmd == CMD_WRITE) || (cmd == CMD_READ);
      e     = '0;
      e.cmd          = cmd;
      e.addr         = addr;
      e.data         = data;
      e.stop_ok      = stop_ok;
      e.reset_before = reset_before;
      e.group_end    = group_end;
      if (reset_before) begin
         for (int i = 0; i < MEM_DEPTH; i++) begin
            model[i] = '0;
         end
         model_trapped = 1'b0;
      end
      if (!known || !stop_ok) begin
         e.nbytes = 2'd1;
      end else begin
         e.nbytes = (cmd == CMD_WRITE) ? 2'd3 : 2'd2;
      end
      if (!model_trapped && (!known || !stop_ok)) begin
         model_trapped = 1'b1;
      end else if (!model_trapped && cmd == CMD_WRITE) begin
         model[a]    = data;
         e.has_reply = 1'b1;
         e.exp_reply = REPLY_ACK;
      end else if (!model_trapped) begin
         e.has_reply = 1'b1;
         e.exp_reply = model[a];
      end
      e.exp_trap               = model_trapped;
      cmd_table[num_entries]   = e;
      cmd_names[num_entries]   = name;
      num_entries++;
   endtask

   task automatic send_command(input int idx);
      cmd_entry_t e;
      data_t      bytes [3];
      logic       stop_bit;
      e        = cmd_table[idx];
      bytes[0] = e.cmd;
      bytes[1] = e.addr;
      bytes[2] = e.data;
      for (int k = 0; k < e.nbytes; k++) begin
         // only the last byte carries the chosen stop bit
         stop_bit = (k == e.nbytes - 1) ? e.stop_ok : 1'b1;
         send_byte(bytes[k], stop_bit);
      end
   endtask

   task automatic collect_replies(input int first, input int last);
      data_t value;
      logic  got;
      for (int j = first; j <= last; j++) begin
         recv_byte(value, got, REPLY_TIMEOUT);
         if (cmd_table[j].has_reply && !got) begin
            $display("no reply came for %s within %0d cycles", cmd_names[j], REPLY_TIMEOUT);
            abort_run();
         end else if (!cmd_table[j].has_reply && got) begin
            $display("%s got a reply although none should come", cmd_names[j]);
            abort_run();
         end else if (got) begin
            check_data(cmd_names[j], cmd_table[j].exp_reply, value);
         end
      end
   endtask

   initial begin : main_flow
      int    first;
      int    last;
      addr_t rnd_addr [4];
      data_t rnd_data [4];
      rst_n         = 1'b0;
      uart_rxd      = 1'b1;
      num_entries   = 0;
      model_trapped = 1'b0;
      for (int i = 0; i < MEM_DEPTH; i++) begin
         model[i] = '0;
      end
      void'($urandom(63));
      for (int i = 0; i < 4; i++) begin
         rnd_addr[i] = addr_t'($urandom_range(MEM_DEPTH - 1, 0));
         rnd_data[i] = data_t'($urandom);
      end

      add_entry("write_rand", CMD_WRITE, {4'h0, rnd_addr[0]}, rnd_data[0], 1, 0, 1);
      add_entry("read_after_write", CMD_READ, {4'h0, rnd_addr[0]}, 8'h00, 1, 0, 1);
      add_entry("read_unwritten", CMD_READ, {4'h0, rnd_addr[0] ^ 4'h8}, 8'h00, 1, 0, 1);
      add_entry("write_second", CMD_WRITE, {4'h0, rnd_addr[1]}, rnd_data[1], 1, 0, 1);
      add_entry("read_alias", CMD_READ, {4'hA, rnd_addr[1]}, 8'h00, 1, 0, 1);
      // sent without gaps, replies overlap the next command
      add_entry("b2b_write_a", CMD_WRITE, {4'h0, rnd_addr[2]}, rnd_data[2], 1, 0, 0);
      add_entry("b2b_read_a", CMD_READ, {4'h0, rnd_addr[2]}, 8'h00, 1, 0, 0);
      add_entry("b2b_write_b", CMD_WRITE, {4'h3, rnd_addr[3]}, rnd_data[3], 1, 0, 0);
      add_entry("b2b_read_first", CMD_READ, {4'h0, rnd_addr[0]}, 8'h00, 1, 0, 1);
      add_entry("unknown_cmd", 8'h41, 8'h00, 8'h00, 1, 0, 1);
      add_entry("write_when_trapped", CMD_WRITE, {4'h0, rnd_addr[0]}, 8'h5A, 1, 0, 1);
      add_entry("read_when_trapped", CMD_READ, {4'h0, rnd_addr[0]}, 8'h00, 1, 0, 1);
      add_entry("frame_error", CMD_READ, {4'h0, rnd_addr[0]}, 8'h00, 0, 1, 1);

      apply_reset();
      repeat (4 * CLKS_PER_BIT) begin
         @(negedge clk);
         check_trap("idle_after_reset", 1'b0, trap);
         check_line("idle_after_reset", 1'b1, uart_txd);
      end

      first = 0;
      while (first < num_entries) begin
         last = first;
         while (!cmd_table[last].group_end) begin
            last++;
         end
         if (cmd_table[first].reset_before) begin
            apply_reset();
         end
         fork
            begin
               for (int j = first; j <= last; j++) begin
                  send_command(j);
               end
            end
            collect_replies(first, last);
         join
         check_trap(cmd_names[last], cmd_table[last].exp_trap, trap);
         first = last + 1;
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
logic/sys_pkg.sv
logic/reset_pulse_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/word_mem.sv
logic/monitor_engine.sv
logic/top_system.sv
testbench/tb_top_system.sv
